//--- hdl/masku_pkg.sv
package masku_pkg;

  //////////////////////////////
  // Datapath widths
  //////////////////////////////

  // Lane word width in bits
  parameter int unsigned ELEN = 64;
  // Bytes per lane word
  parameter int unsigned ELENB = ELEN / 8;
  // Vector length field, max vl is 1024
  parameter int unsigned VL_WIDTH = 11;
  // Register file word address
  parameter int unsigned ADDR_WIDTH = 8;
  // Instruction id
  parameter int unsigned ID_WIDTH = 3;
  // Entries in each lane result queue
  parameter int unsigned RESULT_QUEUE_DEPTH = 2;

  //////////////////////////////
  // Opcodes
  //////////////////////////////

  // Mask-logical family, A is source one and B is source two
  typedef enum logic [2:0] {
    VMANDNOT = 3'd0,
    VMAND    = 3'd1,
    VMOR     = 3'd2,
    VMXOR    = 3'd3,
    VMORNOT  = 3'd4,
    VMNAND   = 3'd5,
    VMNOR    = 3'd6,
    VMXNOR   = 3'd7
  } mask_op_e;

  //////////////////////////////
  // FSM states
  //////////////////////////////

  // Issue unit, one instruction in flight
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    RUN   = 2'd1,
    DRAIN = 2'd2
  } issue_state_e;

endpackage

//--- hdl/masku_issue.sv
`timescale 1ns/1ps

module masku_issue #(
  parameter int unsigned NR_LANES = 2
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                req_valid_i,
  input  masku_pkg::mask_op_e                 req_op_i,
  input  logic [masku_pkg::VL_WIDTH-1:0]      req_vl_i,
  input  logic [masku_pkg::ADDR_WIDTH-1:0]    req_vd_i,
  input  logic [masku_pkg::ID_WIDTH-1:0]      req_id_i,
  input  logic [NR_LANES-1:0]                 operand_valid_i,
  input  logic [NR_LANES-1:0]                 queue_room_i,
  input  logic                                commit_done_i,
  output logic                                req_ready_o,
  output logic                                operand_ready_o,
  output logic                                beat_o,
  output masku_pkg::mask_op_e                 beat_op_o,
  output logic [masku_pkg::ADDR_WIDTH-1:0]    beat_addr_o,
  output logic [masku_pkg::VL_WIDTH-1:0]      beat_rem_o,
  output logic [masku_pkg::VL_WIDTH-1:0]      total_beats_o,
  output logic [masku_pkg::ID_WIDTH-1:0]      inst_id_o
);

  // Bits consumed by one beat across all lanes
  localparam int unsigned BEAT_BITS  = masku_pkg::ELEN * NR_LANES;
  localparam int unsigned BEAT_SHIFT = $clog2(BEAT_BITS);
  localparam int unsigned VLW        = masku_pkg::VL_WIDTH;

  masku_pkg::issue_state_e state_q, state_d;

  // Instruction register
  masku_pkg::mask_op_e              op_q;
  logic [masku_pkg::ADDR_WIDTH-1:0] vd_q;
  logic [masku_pkg::ID_WIDTH-1:0]   id_q;
  logic [VLW-1:0]                   total_q;

  // Progress counters
  logic [VLW-1:0] rem_q;
  logic [VLW-1:0] beat_cnt_q;

  logic [VLW:0]   vl_round;
  logic [VLW-1:0] beats_calc;
  logic           accept;
  logic           last_beat;

  //////////////////////////////
  // Handshakes
  //////////////////////////////

  assign req_ready_o = (state_q == masku_pkg::IDLE);
  assign accept      = req_ready_o & req_valid_i;

  // Every lane must present its words and have queue room
  assign operand_ready_o = (state_q == masku_pkg::RUN) & (&operand_valid_i) & (&queue_room_i);
  assign beat_o          = operand_ready_o;
  assign last_beat       = beat_o & (beat_cnt_q == total_q - VLW'(1));

  // Ceiling of vl over the beat width, vl of zero still takes one beat
  assign vl_round   = {1'b0, req_vl_i} + (VLW + 1)'(BEAT_BITS - 1);
  assign beats_calc = (req_vl_i == '0) ? VLW'(1) : VLW'(vl_round >> BEAT_SHIFT);

  // Broadcast to the slices
  assign beat_op_o     = op_q;
  assign beat_addr_o   = vd_q + beat_cnt_q[masku_pkg::ADDR_WIDTH-1:0];
  assign beat_rem_o    = rem_q;
  assign total_beats_o = total_q;
  assign inst_id_o     = id_q;

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      masku_pkg::IDLE:  if (accept) state_d = masku_pkg::RUN;
      masku_pkg::RUN:   if (last_beat) state_d = masku_pkg::DRAIN;
      masku_pkg::DRAIN: if (commit_done_i) state_d = masku_pkg::IDLE;
      default:          state_d = masku_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= masku_pkg::IDLE;
      rem_q      <= '0;
      beat_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        rem_q      <= req_vl_i;
        beat_cnt_q <= '0;
      end else if (beat_o) begin
        beat_cnt_q <= beat_cnt_q + VLW'(1);
        // Saturate at zero on the tail beat
        rem_q      <= (rem_q > VLW'(BEAT_BITS)) ? rem_q - VLW'(BEAT_BITS) : '0;
      end
    end
  end

  // Latched at acceptance
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q    <= req_op_i;
      vd_q    <= req_vd_i;
      id_q    <= req_id_i;
      total_q <= beats_calc;
    end
  end

endmodule

//--- hdl/masku_lane_slice.sv
`timescale 1ns/1ps

module masku_lane_slice #(
  parameter int unsigned LANE_IDX = 0,
  parameter int unsigned NR_LANES = 2
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                beat_i,
  input  masku_pkg::mask_op_e                 beat_op_i,
  input  logic [masku_pkg::ADDR_WIDTH-1:0]    beat_addr_i,
  input  logic [masku_pkg::VL_WIDTH-1:0]      beat_rem_i,
  input  logic [masku_pkg::ELEN-1:0]          operand_a_i,
  input  logic [masku_pkg::ELEN-1:0]          operand_b_i,
  input  logic [masku_pkg::ELEN-1:0]          operand_vd_i,
  input  logic                                result_gnt_i,
  output logic                                queue_room_o,
  output logic                                pop_o,
  output logic                                result_req_o,
  output logic [masku_pkg::ADDR_WIDTH-1:0]    result_addr_o,
  output logic [masku_pkg::ELEN-1:0]          result_wdata_o,
  output logic [masku_pkg::ELENB-1:0]         result_be_o
);

  localparam int unsigned ELEN      = masku_pkg::ELEN;
  localparam int unsigned VLW       = masku_pkg::VL_WIDTH;
  localparam int unsigned DEPTH     = masku_pkg::RESULT_QUEUE_DEPTH;
  localparam int unsigned PTR_W     = $clog2(DEPTH);
  localparam int unsigned CNT_W     = $clog2(DEPTH + 1);
  localparam int unsigned SHARE_W   = $clog2(ELEN) + 1;
  localparam int unsigned BEAT_BITS = ELEN * NR_LANES;
  localparam int unsigned LANE_OFS  = LANE_IDX * ELEN;

  logic [VLW-1:0]                beat_bits;
  logic [SHARE_W-1:0]            share;
  logic [ELEN-1:0]               bit_en;
  logic [ELEN-1:0]               op_res;
  logic [ELEN-1:0]               merged;
  logic [masku_pkg::ELENB-1:0]   byte_en;

  //////////////////////////////
  // Tail enable
  //////////////////////////////

  // Bits of this beat, then this lane's slice of them
  assign beat_bits = (beat_rem_i > VLW'(BEAT_BITS)) ? VLW'(BEAT_BITS) : beat_rem_i;

  always_comb begin
    if (beat_bits <= VLW'(LANE_OFS)) begin
      share = '0;
    end else if (beat_bits - VLW'(LANE_OFS) >= VLW'(ELEN)) begin
      share = SHARE_W'(ELEN);
    end else begin
      share = SHARE_W'(beat_bits - VLW'(LANE_OFS));
    end
  end

  // Thermometer of the active bits
  always_comb begin
    for (int i = 0; i < ELEN; i++) begin
      bit_en[i] = (i < int'(share));
    end
  end

  // Byte is written if it holds any active bit
  always_comb begin
    for (int b = 0; b < masku_pkg::ELENB; b++) begin
      byte_en[b] = |bit_en[8*b +: 8];
    end
  end

  //////////////////////////////
  // Logic op and merge
  //////////////////////////////

  always_comb begin
    op_res = '0;
    case (beat_op_i)
      masku_pkg::VMANDNOT: op_res = operand_a_i & ~operand_b_i;
      masku_pkg::VMAND:    op_res = operand_a_i & operand_b_i;
      masku_pkg::VMOR:     op_res = operand_a_i | operand_b_i;
      masku_pkg::VMXOR:    op_res = operand_a_i ^ operand_b_i;
      masku_pkg::VMORNOT:  op_res = operand_a_i | ~operand_b_i;
      masku_pkg::VMNAND:   op_res = ~(operand_a_i & operand_b_i);
      masku_pkg::VMNOR:    op_res = ~(operand_a_i | operand_b_i);
      masku_pkg::VMXNOR:   op_res = ~(operand_a_i ^ operand_b_i);
      default:             op_res = '0;
    endcase
  end

  // Old destination bits survive above vl
  assign merged = (op_res & bit_en) | (operand_vd_i & ~bit_en);

  //////////////////////////////
  // Result queue
  //////////////////////////////

  logic [masku_pkg::ADDR_WIDTH-1:0] q_addr  [DEPTH];
  logic [ELEN-1:0]                  q_wdata [DEPTH];
  logic [masku_pkg::ELENB-1:0]      q_be    [DEPTH];
  logic [PTR_W-1:0]                 rd_ptr_q, wr_ptr_q;
  logic [CNT_W-1:0]                 cnt_q;

  assign queue_room_o   = (cnt_q != CNT_W'(DEPTH));
  assign result_req_o   = (cnt_q != '0);
  assign pop_o          = result_req_o & result_gnt_i;
  assign result_addr_o  = q_addr[rd_ptr_q];
  assign result_wdata_o = q_wdata[rd_ptr_q];
  assign result_be_o    = q_be[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (beat_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
      end
      if (pop_o) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
      end
      // Simultaneous push and pop keeps the count
      cnt_q <= cnt_q + CNT_W'(beat_i) - CNT_W'(pop_o);
    end
  end

  always_ff @(posedge clk_i) begin
    if (beat_i) begin
      q_addr[wr_ptr_q]  <= beat_addr_i;
      q_wdata[wr_ptr_q] <= merged;
      q_be[wr_ptr_q]    <= byte_en;
    end
  end

endmodule

//--- hdl/masku_commit.sv
`timescale 1ns/1ps

module masku_commit #(
  parameter int unsigned NR_LANES = 2
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic [NR_LANES-1:0]               pop_i,
  input  logic [masku_pkg::VL_WIDTH-1:0]    total_beats_i,
  input  logic [masku_pkg::ID_WIDTH-1:0]    inst_id_i,
  input  logic                              active_i,
  output logic                              done_o,
  output logic [masku_pkg::ID_WIDTH-1:0]    done_id_o,
  output logic                              commit_done_o
);

  localparam int unsigned VLW = masku_pkg::VL_WIDTH;

  // Words written so far, one counter per lane
  logic [VLW-1:0] cnt_q [NR_LANES];
  logic           all_written;

  //////////////////////////////
  // Completion check
  //////////////////////////////

  always_comb begin
    all_written = 1'b1;
    for (int l = 0; l < NR_LANES; l++) begin
      if (cnt_q[l] != total_beats_i) all_written = 1'b0;
    end
  end

  // Issue unit leaves DRAIN on this
  assign commit_done_o = active_i & all_written;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int l = 0; l < NR_LANES; l++) begin
        cnt_q[l] <= '0;
      end
    end else begin
      for (int l = 0; l < NR_LANES; l++) begin
        if (commit_done_o) begin
          cnt_q[l] <= '0;
        end else if (pop_i[l]) begin
          cnt_q[l] <= cnt_q[l] + VLW'(1);
        end
      end
    end
  end

  // One-cycle done pulse with the instruction id
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_o    <= 1'b0;
      done_id_o <= '0;
    end else begin
      done_o <= commit_done_o;
      if (commit_done_o) done_id_o <= inst_id_i;
    end
  end

endmodule

//--- hdl/masku_top.sv
`timescale 1ns/1ps

module masku_top #(
  parameter int unsigned NR_LANES = 2
) (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  // Sequencer request
  input  logic                                              req_valid_i,
  output logic                                              req_ready_o,
  input  masku_pkg::mask_op_e                               req_op_i,
  input  logic [masku_pkg::VL_WIDTH-1:0]                    req_vl_i,
  input  logic [masku_pkg::ADDR_WIDTH-1:0]                  req_vd_i,
  input  logic [masku_pkg::ID_WIDTH-1:0]                    req_id_i,
  // Operand words, one set per lane
  input  logic [NR_LANES-1:0][masku_pkg::ELEN-1:0]          operand_a_i,
  input  logic [NR_LANES-1:0][masku_pkg::ELEN-1:0]          operand_b_i,
  input  logic [NR_LANES-1:0][masku_pkg::ELEN-1:0]          operand_vd_i,
  input  logic [NR_LANES-1:0]                               operand_valid_i,
  output logic                                              operand_ready_o,
  // Register file writes
  output logic [NR_LANES-1:0]                               result_req_o,
  output logic [NR_LANES-1:0][masku_pkg::ADDR_WIDTH-1:0]    result_addr_o,
  output logic [NR_LANES-1:0][masku_pkg::ELEN-1:0]          result_wdata_o,
  output logic [NR_LANES-1:0][masku_pkg::ELENB-1:0]         result_be_o,
  input  logic [NR_LANES-1:0]                               result_gnt_i,
  // Completion
  output logic                                              done_o,
  output logic [masku_pkg::ID_WIDTH-1:0]                    done_id_o
);

  // Issue broadcast
  logic                             beat;
  masku_pkg::mask_op_e              beat_op;
  logic [masku_pkg::ADDR_WIDTH-1:0] beat_addr;
  logic [masku_pkg::VL_WIDTH-1:0]   beat_rem;
  logic [masku_pkg::VL_WIDTH-1:0]   total_beats;
  logic [masku_pkg::ID_WIDTH-1:0]   inst_id;
  logic                             commit_done;

  // Per-lane status back from the slices
  logic [NR_LANES-1:0]              queue_room;
  logic [NR_LANES-1:0]              pop;

  masku_issue #(.NR_LANES(NR_LANES)) masku_issue_inst (
    .clk_i, .rst_ni, .req_valid_i, .req_op_i, .req_vl_i, .req_vd_i, .req_id_i,
    .operand_valid_i,
    .queue_room_i   (queue_room),
    .commit_done_i  (commit_done),
    .req_ready_o, .operand_ready_o,
    .beat_o         (beat),
    .beat_op_o      (beat_op),
    .beat_addr_o    (beat_addr),
    .beat_rem_o     (beat_rem),
    .total_beats_o  (total_beats),
    .inst_id_o      (inst_id)
  );

  //////////////////////////////
  // Lane slices
  //////////////////////////////

  for (genvar l = 0; l < NR_LANES; l++) begin : gen_lanes
    masku_lane_slice #(.LANE_IDX(l), .NR_LANES(NR_LANES)) masku_lane_slice_inst (
      .clk_i, .rst_ni,
      .beat_i         (beat),
      .beat_op_i      (beat_op),
      .beat_addr_i    (beat_addr),
      .beat_rem_i     (beat_rem),
      .operand_a_i    (operand_a_i[l]),
      .operand_b_i    (operand_b_i[l]),
      .operand_vd_i   (operand_vd_i[l]),
      .result_gnt_i   (result_gnt_i[l]),
      .queue_room_o   (queue_room[l]),
      .pop_o          (pop[l]),
      .result_req_o   (result_req_o[l]),
      .result_addr_o  (result_addr_o[l]),
      .result_wdata_o (result_wdata_o[l]),
      .result_be_o    (result_be_o[l])
    );
  end

  // Issue is busy whenever it refuses requests
  masku_commit #(.NR_LANES(NR_LANES)) masku_commit_inst (
    .clk_i, .rst_ni,
    .pop_i         (pop),
    .total_beats_i (total_beats),
    .inst_id_i     (inst_id),
    .active_i      (~req_ready_o),
    .done_o, .done_id_o,
    .commit_done_o (commit_done)
  );

endmodule

//--- test/tb_masku.sv
`timescale 1ns/1ps

module tb_masku;

  localparam int unsigned NR_LANES  = 2;
  localparam int unsigned MAX_TESTS = 16;
  localparam int unsigned MAX_BEATS = 64;
  localparam int unsigned TIMEOUT   = 2000;
  localparam logic [31:0] SEED      = 32'h4e86ad72;

  logic clk_i = 1'b0;
  logic rst_ni = 1'b0;
  logic req_valid_i = 1'b0;
  logic req_ready_o;
  masku_pkg::mask_op_e req_op_i = masku_pkg::VMANDNOT;
  logic [10:0] req_vl_i = '0;
  logic [7:0] req_vd_i = '0;
  logic [2:0] req_id_i = '0;
  logic [NR_LANES-1:0][63:0] operand_a_i = '0;
  logic [NR_LANES-1:0][63:0] operand_b_i = '0;
  logic [NR_LANES-1:0][63:0] operand_vd_i = '0;
  logic [NR_LANES-1:0] operand_valid_i = '0;
  logic operand_ready_o;
  logic [NR_LANES-1:0] result_req_o;
  logic [NR_LANES-1:0][7:0] result_addr_o;
  logic [NR_LANES-1:0][63:0] result_wdata_o;
  logic [NR_LANES-1:0][7:0] result_be_o;
  logic [NR_LANES-1:0] result_gnt_i = '0;
  logic done_o;
  logic [2:0] done_id_o;

  // Golden data with the beats of all tests stored back to back
  int unsigned t_op [MAX_TESTS];
  int unsigned t_vl [MAX_TESTS];
  logic [7:0] t_vd [MAX_TESTS];
  logic [2:0] t_id [MAX_TESTS];
  int unsigned t_base [MAX_TESTS];
  int unsigned t_nb [MAX_TESTS];
  logic [63:0] in_a [NR_LANES][MAX_BEATS];
  logic [63:0] in_b [NR_LANES][MAX_BEATS];
  logic [63:0] in_vd [NR_LANES][MAX_BEATS];
  logic [63:0] exp_w [NR_LANES][MAX_BEATS];
  logic [7:0] exp_be [NR_LANES][MAX_BEATS];
  int unsigned n_tests;

  // Instruction in flight as seen by the monitor
  int unsigned cur_base;
  int unsigned cur_nb;
  logic [7:0] cur_vd;
  logic [2:0] cur_id;
  logic test_active = 1'b0;
  int unsigned wr_cnt [NR_LANES];
  int unsigned done_cnt = 0;
  int unsigned err_cnt = 0;
  logic timed_out = 1'b0;
  logic [31:0] lfsr = SEED;

  masku_top #(.NR_LANES(NR_LANES)) masku_top_inst (.*);

  always #20 clk_i = ~clk_i;

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  //////////////////////////////
  // Grants and write monitor
  //////////////////////////////

  // Grant is set on the falling edge, so a write with req and gnt high pops on the next rise
  always @(negedge clk_i) begin
    for (int l = 0; l < NR_LANES; l++) begin
      lfsr = lfsr_step(lfsr);
      result_gnt_i[l] = lfsr[0];
      if (result_req_o[l] && lfsr[0]) begin
        assert (test_active && wr_cnt[l] < cur_nb) else begin
          $display("Lane %0d wrote a word that no instruction expects", l);
          err_cnt++;
        end
        if (test_active && wr_cnt[l] < cur_nb) begin
          assert (result_addr_o[l] == cur_vd + 8'(wr_cnt[l])) else begin
            $display("MISMATCH %0t lane %0d addr %h", $time, l, result_addr_o[l]);
            err_cnt++;
          end
          assert (result_wdata_o[l] == exp_w[l][cur_base + wr_cnt[l]]) else begin
            $display("MISMATCH %0t lane %0d wdata %h expected %h", $time, l,
                     result_wdata_o[l], exp_w[l][cur_base + wr_cnt[l]]);
            err_cnt++;
          end
          assert (result_be_o[l] == exp_be[l][cur_base + wr_cnt[l]]) else begin
            $display("MISMATCH %0t lane %0d be %h expected %h", $time, l,
                     result_be_o[l], exp_be[l][cur_base + wr_cnt[l]]);
            err_cnt++;
          end
          wr_cnt[l]++;
        end
      end
    end
    if (done_o) begin
      assert (test_active) else begin
        $display("Done pulse with no instruction in flight");
        err_cnt++;
      end
      if (test_active) begin
        assert (done_id_o == cur_id && wr_cnt[0] == cur_nb && wr_cnt[1] == cur_nb) else begin
          $display("MISMATCH %0t done id %0d writes %0d/%0d of %0d", $time, done_id_o,
                   wr_cnt[0], wr_cnt[1], cur_nb);
          err_cnt++;
        end
        test_active = 1'b0;
        done_cnt++;
      end
    end
  end

  //////////////////////////////
  // Stimulus tasks
  //////////////////////////////

  task automatic load_golden();
    int fd;
    int r;
    logic [8*200-1:0] line;
    int unsigned op, vl, vd, id;
    int unsigned nb;
    fd = $fopen("test/masku_golden.txt", "r");
    n_tests = 0;
    if (fd == 0) begin
      $display("Cannot open the golden file");
      timed_out = 1'b1;
      return;
    end
    // Two column description lines
    r = $fgets(line, fd);
    r = $fgets(line, fd);
    nb = 0;
    while (n_tests < MAX_TESTS) begin
      r = $fscanf(fd, "%h %h %h %h\n", op, vl, vd, id);
      if (r != 4) break;
      t_op[n_tests] = op;
      t_vl[n_tests] = vl;
      t_vd[n_tests] = 8'(vd);
      t_id[n_tests] = 3'(id);
      t_base[n_tests] = nb;
      // Ceiling of vl over 128 bits and never less than one beat
      t_nb[n_tests] = (vl == 0) ? 1 : (vl + 127) / 128;
      for (int b = 0; b < int'(t_nb[n_tests]); b++) begin
        r = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h\n",
                    in_a[0][nb], in_b[0][nb], in_vd[0][nb],
                    in_a[1][nb], in_b[1][nb], in_vd[1][nb],
                    exp_w[0][nb], exp_be[0][nb], exp_w[1][nb], exp_be[1][nb]);
        nb++;
      end
      n_tests++;
    end
    $fclose(fd);
  endtask

  // Request port stays closed while an instruction is in flight
  task automatic check_busy(input int unsigned t);
    assert (!req_ready_o) else begin
      $display("MISMATCH %0t req_ready_o high before done in test %0d", $time, t);
      err_cnt++;
    end
  endtask

  task automatic send_request(input int unsigned t);
    int unsigned n;
    cur_base = t_base[t];
    cur_nb = t_nb[t];
    cur_vd = t_vd[t];
    cur_id = t_id[t];
    wr_cnt[0] = 0;
    wr_cnt[1] = 0;
    test_active = 1'b1;
    req_valid_i = 1'b1;
    req_op_i = masku_pkg::mask_op_e'(t_op[t]);
    req_vl_i = 11'(t_vl[t]);
    req_vd_i = t_vd[t];
    req_id_i = t_id[t];
    #1;
    n = 0;
    while (!req_ready_o) begin
      if (n == TIMEOUT) begin
        $display("Timeout waiting for req_ready_o in test %0d", t);
        timed_out = 1'b1;
        return;
      end
      @(negedge clk_i);
      #1;
      n++;
    end
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  task automatic send_beats(input int unsigned t);
    int unsigned n;
    int unsigned idx;
    for (int b = 0; b < int'(t_nb[t]); b++) begin
      idx = t_base[t] + b;
      for (int l = 0; l < NR_LANES; l++) begin
        operand_a_i[l] = in_a[l][idx];
        operand_b_i[l] = in_b[l][idx];
        operand_vd_i[l] = in_vd[l][idx];
      end
      operand_valid_i = '1;
      #1;
      check_busy(t);
      n = 0;
      while (!operand_ready_o) begin
        if (n == TIMEOUT) begin
          $display("Timeout waiting for operand_ready_o, test %0d beat %0d", t, b);
          timed_out = 1'b1;
          return;
        end
        @(negedge clk_i);
        #1;
        check_busy(t);
        n++;
      end
      @(negedge clk_i);
      operand_valid_i = '0;
    end
  endtask

  task automatic wait_done(input int unsigned t);
    int unsigned n;
    n = 0;
    #1;
    while (done_cnt != t + 1) begin
      check_busy(t);
      if (n == TIMEOUT) begin
        $display("Timeout waiting for done_o in test %0d", t);
        timed_out = 1'b1;
        return;
      end
      @(negedge clk_i);
      #1;
      n++;
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    int unsigned err_before;
    int unsigned n_run;
    n_run = 0;
    load_golden();
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    assert (req_ready_o && !operand_ready_o && result_req_o == '0 && !done_o) else begin
      $display("MISMATCH %0t outputs wrong after reset", $time);
      err_cnt++;
    end
    for (int unsigned t = 0; t < n_tests && !timed_out; t++) begin
      err_before = err_cnt;
      @(negedge clk_i);
      send_request(t);
      if (!timed_out) send_beats(t);
      if (!timed_out) wait_done(t);
      if (!timed_out) begin
        n_run++;
        $display("test %0d op %0d vl %0d: %s", t, t_op[t], t_vl[t],
                 (err_cnt == err_before) ? "ok" : "errors");
      end
    end
    $display("tests run %0d of %0d, errors %0d", n_run, n_tests, err_cnt);
    if (err_cnt == 0 && !timed_out && n_tests > 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- test/masku_golden.txt
# block: op vl vd id (hex), then one line per beat
# a0 b0 vd0 a1 b1 vd1 wdata0 be0 wdata1 be1
0 080 10 0
00FF00FF00FF00FF 0F0F0F0F0F0F0F0F 0123456789ABCDEF 3333333333333333 5555555555555555 FEDCBA9876543210 00F000F000F000F0 FF 2222222222222222 FF
1 080 11 1
00FF00FF00FF00FF 0F0F0F0F0F0F0F0F 0123456789ABCDEF 3333333333333333 5555555555555555 FEDCBA9876543210 000F000F000F000F FF 1111111111111111 FF
2 080 12 2
00FF00FF00FF00FF 0F0F0F0F0F0F0F0F 0123456789ABCDEF 3333333333333333 5555555555555555 FEDCBA9876543210 0FFF0FFF0FFF0FFF FF 7777777777777777 FF
3 080 13 3
00FF00FF00FF00FF 0F0F0F0F0F0F0F0F 0123456789ABCDEF 3333333333333333 5555555555555555 FEDCBA9876543210 0FF00FF00FF00FF0 FF 6666666666666666 FF
4 080 14 4
00FF00FF00FF00FF 0F0F0F0F0F0F0F0F 0123456789ABCDEF 3333333333333333 5555555555555555 FEDCBA9876543210 F0FFF0FFF0FFF0FF FF BBBBBBBBBBBBBBBB FF
5 080 15 5
00FF00FF00FF00FF 0F0F0F0F0F0F0F0F 0123456789ABCDEF 3333333333333333 5555555555555555 FEDCBA9876543210 FFF0FFF0FFF0FFF0 FF EEEEEEEEEEEEEEEE FF
6 080 16 6
00FF00FF00FF00FF 0F0F0F0F0F0F0F0F 0123456789ABCDEF 3333333333333333 5555555555555555 FEDCBA9876543210 F000F000F000F000 FF 8888888888888888 FF
7 080 17 7
00FF00FF00FF00FF 0F0F0F0F0F0F0F0F 0123456789ABCDEF 3333333333333333 5555555555555555 FEDCBA9876543210 F00FF00FF00FF00F FF 9999999999999999 FF
1 046 30 2
00FF00FF00FF00FF 0F0F0F0F0F0F0F0F 0123456789ABCDEF 3333333333333333 5555555555555555 AAAAAAAAAAAAAAAA 000F000F000F000F FF AAAAAAAAAAAAAA91 01
3 190 40 5
1111111111111111 0000000000000000 CCCCCCCCCCCCCCCC 5555555555555555 0000000000000000 DDDDDDDDDDDDDDDD 1111111111111111 FF 5555555555555555 FF
2222222222222222 0000000000000000 CCCCCCCCCCCCCCCC 6666666666666666 0000000000000000 DDDDDDDDDDDDDDDD 2222222222222222 FF 6666666666666666 FF
3333333333333333 0000000000000000 CCCCCCCCCCCCCCCC 7777777777777777 0000000000000000 DDDDDDDDDDDDDDDD 3333333333333333 FF 7777777777777777 FF
4444444444444444 0000000000000000 CCCCCCCCCCCCCCCC 8888888888888888 0000000000000000 DDDDDDDDDDDDDDDD CCCCCCCCCCCC4444 03 DDDDDDDDDDDDDDDD 00
2 000 50 6
00FF00FF00FF00FF 0F0F0F0F0F0F0F0F 0123456789ABCDEF 3333333333333333 5555555555555555 FEDCBA9876543210 0123456789ABCDEF 00 FEDCBA9876543210 00

//--- all.f
hdl/masku_pkg.sv
hdl/masku_issue.sv
hdl/masku_lane_slice.sv
hdl/masku_commit.sv
hdl/masku_top.sv
test/tb_masku.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing
TOP       ?= tb_masku
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := Test completed successfully

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) hdl/*.sv test/*.sv
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
